/* verilog/ucodePkg.sv */
`default_nettype none

package ucodePkg;

	//////////////////////////////////////////////////
	// Micro-ROM addressing and word fields
	//////////////////////////////////////////////////

	typedef logic [6:0] flowIdxT;

	typedef enum logic [3:0] {
		ctlOp          = 4'd0,
		ctlInc         = 4'd1,
		ctlEof         = 4'd2,
		ctlIncEof      = 4'd3,
		ctlIncEofZ     = 4'd4,
		ctlIncEofNz    = 4'd5,
		ctlEofFu       = 4'd6,
		ctlIncEofFu    = 4'd7,
		ctlUpdateFlags = 4'd8
	} flowCtlT;

	typedef enum logic [4:0] {
		opNop     = 5'd0,
		opSma     = 5'd1,
		opSmw     = 5'd2,
		opSrm     = 5'd3,
		opInc16   = 5'd4,
		opDec16   = 5'd5,
		opSx16r   = 5'd6,
		opSrx16   = 5'd7,
		opAddx16  = 5'd8,
		opSubx16  = 5'd9,
		opBit     = 5'd10,
		opShl     = 5'd11,
		opSpc     = 5'd12,
		opAddx8   = 5'd13,
		opZ801bop = 5'd14
	} uopOpT;

	// Operand codes, bit 4 marks a register pair
	localparam logic [4:0] regA    = 5'h00;
	localparam logic [4:0] regB    = 5'h01;
	localparam logic [4:0] regC    = 5'h02;
	localparam logic [4:0] regD    = 5'h03;
	localparam logic [4:0] regE    = 5'h04;
	localparam logic [4:0] regH    = 5'h05;
	localparam logic [4:0] regL    = 5'h06;
	localparam logic [4:0] regX8   = 5'h07;
	localparam logic [4:0] regNull = 5'h0F;
	localparam logic [4:0] pairBc  = 5'h10;
	localparam logic [4:0] pairDe  = 5'h11;
	localparam logic [4:0] pairHl  = 5'h12;
	localparam logic [4:0] pairSp  = 5'h13;
	localparam logic [4:0] pairPc  = 5'h14;

	typedef struct packed {
		flowCtlT    flowCtl;
		uopOpT      operation;
		logic [4:0] operand;
	} ucodeRegT;

	// PC lands in the spare bits, pair index reads 0 for it
	typedef struct packed {
		flowCtlT    flowCtl;
		uopOpT      operation;
		logic       isPair;
		logic [1:0] spare;
		logic [1:0] pairIdx;
	} ucodePairT;

	typedef union packed {
		ucodeRegT  asReg;
		ucodePairT asPair;
	} ucodeWordU;

	//////////////////////////////////////////////////
	// Flow start rows, packed back to back
	//////////////////////////////////////////////////

	localparam flowIdxT flowDefault   = 7'd0;
	localparam flowIdxT flowNop       = 7'd2;
	localparam flowIdxT flowLdBn      = 7'd3;
	localparam flowIdxT flowIncB      = 7'd6;
	localparam flowIdxT flowDecA      = 7'd7;
	localparam flowIdxT flowAddAB     = 7'd8;
	localparam flowIdxT flowSubC      = 7'd11;
	localparam flowIdxT flowIncHl     = 7'd14;
	localparam flowIdxT flowPushBc    = 7'd15;
	localparam flowIdxT flowPopBc     = 7'd21;
	localparam flowIdxT flowJrNz      = 7'd27;
	localparam flowIdxT flowBit7H     = 7'd33;
	localparam flowIdxT flowRlC       = 7'd34;
	localparam flowIdxT flowCbUnknown = 7'd35;

	// Opcode bytes
	localparam logic [7:0] opcNop      = 8'h00;
	localparam logic [7:0] opcLdBn     = 8'h06;
	localparam logic [7:0] opcIncB     = 8'h04;
	localparam logic [7:0] opcDecA     = 8'h3D;
	localparam logic [7:0] opcAddAB    = 8'h80;
	localparam logic [7:0] opcSubC     = 8'h91;
	localparam logic [7:0] opcIncHl    = 8'h23;
	localparam logic [7:0] opcPushBc   = 8'hC5;
	localparam logic [7:0] opcPopBc    = 8'hC1;
	localparam logic [7:0] opcJrNz     = 8'h20;
	localparam logic [7:0] opcCbPrefix = 8'hCB;
	localparam logic [7:0] cbBit7H     = 8'h7C;
	localparam logic [7:0] cbRlC       = 8'h11;

endpackage

`default_nettype wire

/* verilog/opcodeDispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module opcodeDispatch
(
	input  wire logic               clock,
	input  wire logic               rstN,
	input  wire logic               opValid,
	input  wire logic [7:0]         opcode,
	output      logic               flowValid,
	output      ucodePkg::flowIdxT  flowIdx
);

	ucodePkg::flowIdxT mainIdx;
	ucodePkg::flowIdxT cbIdx;
	logic              cbPending;
	logic              armCb;

	//////////////////////////////////////////////////
	// Opcode lookup tables
	//////////////////////////////////////////////////

	always_comb
	begin
		case (opcode)
			ucodePkg::opcNop:    mainIdx = ucodePkg::flowNop;
			ucodePkg::opcLdBn:   mainIdx = ucodePkg::flowLdBn;
			ucodePkg::opcIncB:   mainIdx = ucodePkg::flowIncB;
			ucodePkg::opcDecA:   mainIdx = ucodePkg::flowDecA;
			ucodePkg::opcAddAB:  mainIdx = ucodePkg::flowAddAB;
			ucodePkg::opcSubC:   mainIdx = ucodePkg::flowSubC;
			ucodePkg::opcIncHl:  mainIdx = ucodePkg::flowIncHl;
			ucodePkg::opcPushBc: mainIdx = ucodePkg::flowPushBc;
			ucodePkg::opcPopBc:  mainIdx = ucodePkg::flowPopBc;
			ucodePkg::opcJrNz:   mainIdx = ucodePkg::flowJrNz;
			// Anything else runs as a one byte Z80 op
			default:             mainIdx = ucodePkg::flowDefault;
		endcase
	end

	// Second byte after the 0xCB prefix
	always_comb
	begin
		case (opcode)
			ucodePkg::cbBit7H: cbIdx = ucodePkg::flowBit7H;
			ucodePkg::cbRlC:   cbIdx = ucodePkg::flowRlC;
			default:           cbIdx = ucodePkg::flowCbUnknown;
		endcase
	end

	// Prefix byte only arms the CB table
	assign armCb = opValid && !cbPending && (opcode == ucodePkg::opcCbPrefix);

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			flowValid <= 1'b0;
			cbPending <= 1'b0;
		end
		else
		begin
			flowValid <= opValid && !armCb;
			if (opValid)
				cbPending <= armCb;
		end
	end

	always_ff @(posedge clock)
	begin
		if (opValid)
			flowIdx <= cbPending ? cbIdx : mainIdx;
	end

endmodule

`default_nettype wire

/* verilog/flowQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module flowQueue
#(
	parameter int queueDepth = 4
)
(
	input  wire logic               clock,
	input  wire logic               rstN,
	input  wire logic               push,
	input  wire ucodePkg::flowIdxT  pushIdx,
	input  wire logic               pop,
	output      logic               notEmpty,
	output      ucodePkg::flowIdxT  headIdx,
	output      logic               overflow
);

	localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int cntW = $clog2(queueDepth + 1);

	ucodePkg::flowIdxT mem [queueDepth];
	logic [ptrW-1:0]   rdPtr;
	logic [ptrW-1:0]   wrPtr;
	logic [cntW-1:0]   count;
	logic              full;
	logic              doPush;
	logic              doPop;

	// Pointer step with wrap for any depth
	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
		return (ptr == ptrW'(queueDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full     = (count == cntW'(queueDepth));
	assign notEmpty = (count != '0);
	assign doPush   = push && !full;
	assign doPop    = pop && notEmpty;

	// Show-ahead head
	assign headIdx = mem[rdPtr];

	always_ff @(posedge clock)
	begin
		if (doPush)
			mem[wrPtr] <= pushIdx;
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			rdPtr    <= '0;
			wrPtr    <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
			// Sticky until reset
			if (push && full)
				overflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/ucodeRom.sv */
`timescale 1ns/1ps
`default_nettype none

module ucodeRom
(
	input  wire ucodePkg::flowIdxT  addr,
	output      ucodePkg::ucodeWordU word
);

	function automatic ucodePkg::ucodeWordU makeUop(
		input ucodePkg::flowCtlT ctl,
		input ucodePkg::uopOpT   op,
		input logic [4:0]        operand
	);
		ucodePkg::ucodeWordU w;
		w.asReg.flowCtl   = ctl;
		w.asReg.operation = op;
		w.asReg.operand   = operand;
		return w;
	endfunction

	always_comb
	begin
		case (addr)
			// Default one byte op
			ucodePkg::flowDefault:
				word = makeUop(ucodePkg::ctlUpdateFlags, ucodePkg::opZ801bop, ucodePkg::regA);
			ucodePkg::flowDefault + 7'd1:
				word = makeUop(ucodePkg::ctlIncEof, ucodePkg::opNop, ucodePkg::regNull);
			// NOP
			ucodePkg::flowNop:
				word = makeUop(ucodePkg::ctlIncEof, ucodePkg::opNop, ucodePkg::regNull);
			// LD B,n
			ucodePkg::flowLdBn:
				word = makeUop(ucodePkg::ctlInc, ucodePkg::opSma, ucodePkg::pairPc);
			ucodePkg::flowLdBn + 7'd1:
				word = makeUop(ucodePkg::ctlInc, ucodePkg::opNop, ucodePkg::regNull);
			ucodePkg::flowLdBn + 7'd2:
				word = makeUop(ucodePkg::ctlEof, ucodePkg::opSrm, ucodePkg::regB);
			// INC B and DEC A
			ucodePkg::flowIncB:
				word = makeUop(ucodePkg::ctlIncEofFu, ucodePkg::opInc16, ucodePkg::regB);
			ucodePkg::flowDecA:
				word = makeUop(ucodePkg::ctlIncEofFu, ucodePkg::opDec16, ucodePkg::regA);
			// ADD A,B through x16
			ucodePkg::flowAddAB:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opSx16r, ucodePkg::regA);
			ucodePkg::flowAddAB + 7'd1:
				word = makeUop(ucodePkg::ctlUpdateFlags, ucodePkg::opAddx16, ucodePkg::regB);
			ucodePkg::flowAddAB + 7'd2:
				word = makeUop(ucodePkg::ctlIncEof, ucodePkg::opSrx16, ucodePkg::regA);
			// SUB C
			ucodePkg::flowSubC:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opSx16r, ucodePkg::regA);
			ucodePkg::flowSubC + 7'd1:
				word = makeUop(ucodePkg::ctlUpdateFlags, ucodePkg::opSubx16, ucodePkg::regC);
			ucodePkg::flowSubC + 7'd2:
				word = makeUop(ucodePkg::ctlIncEof, ucodePkg::opSrx16, ucodePkg::regA);
			// INC HL
			ucodePkg::flowIncHl:
				word = makeUop(ucodePkg::ctlIncEof, ucodePkg::opInc16, ucodePkg::pairHl);
			// PUSH BC, high byte first
			ucodePkg::flowPushBc:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opDec16, ucodePkg::pairSp);
			ucodePkg::flowPushBc + 7'd1:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opSma, ucodePkg::pairSp);
			ucodePkg::flowPushBc + 7'd2:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opSmw, ucodePkg::regB);
			ucodePkg::flowPushBc + 7'd3:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opDec16, ucodePkg::pairSp);
			ucodePkg::flowPushBc + 7'd4:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opSmw, ucodePkg::regC);
			ucodePkg::flowPushBc + 7'd5:
				word = makeUop(ucodePkg::ctlIncEof, ucodePkg::opSma, ucodePkg::pairPc);
			// POP BC
			ucodePkg::flowPopBc:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opSma, ucodePkg::pairSp);
			ucodePkg::flowPopBc + 7'd1:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opInc16, ucodePkg::pairSp);
			ucodePkg::flowPopBc + 7'd2:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opSrm, ucodePkg::regC);
			ucodePkg::flowPopBc + 7'd3:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opSrm, ucodePkg::regB);
			ucodePkg::flowPopBc + 7'd4:
				word = makeUop(ucodePkg::ctlInc, ucodePkg::opInc16, ucodePkg::pairSp);
			ucodePkg::flowPopBc + 7'd5:
				word = makeUop(ucodePkg::ctlEof, ucodePkg::opSma, ucodePkg::pairPc);
			// JR NZ,n, falls out early when Z is set
			ucodePkg::flowJrNz:
				word = makeUop(ucodePkg::ctlInc, ucodePkg::opSma, ucodePkg::pairPc);
			ucodePkg::flowJrNz + 7'd1:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opNop, ucodePkg::regNull);
			ucodePkg::flowJrNz + 7'd2:
				word = makeUop(ucodePkg::ctlIncEofZ, ucodePkg::opSrm, ucodePkg::regX8);
			ucodePkg::flowJrNz + 7'd3:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opSx16r, ucodePkg::pairPc);
			ucodePkg::flowJrNz + 7'd4:
				word = makeUop(ucodePkg::ctlOp, ucodePkg::opAddx8, ucodePkg::regX8);
			ucodePkg::flowJrNz + 7'd5:
				word = makeUop(ucodePkg::ctlEof, ucodePkg::opSpc, ucodePkg::pairPc);
			// CB page
			ucodePkg::flowBit7H:
				word = makeUop(ucodePkg::ctlEofFu, ucodePkg::opBit, ucodePkg::regH);
			ucodePkg::flowRlC:
				word = makeUop(ucodePkg::ctlEofFu, ucodePkg::opShl, ucodePkg::regC);
			ucodePkg::flowCbUnknown:
				word = makeUop(ucodePkg::ctlEof, ucodePkg::opNop, ucodePkg::regNull);
			default:
				word = makeUop(ucodePkg::ctlEof, ucodePkg::opNop, ucodePkg::regNull);
		endcase
	end

endmodule

`default_nettype wire

/* verilog/ucodeSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ucodeSequencer
(
	input  wire logic                clock,
	input  wire logic                rstN,
	input  wire logic                notEmpty,
	input  wire ucodePkg::flowIdxT   headIdx,
	input  wire logic                zeroFlag,
	output      logic                pop,
	output      ucodePkg::flowIdxT   romAddr,
	input  wire ucodePkg::ucodeWordU romWord,
	output      logic                uopValid,
	output      ucodePkg::uopOpT     uopOperation,
	output      logic                isPair,
	output      logic [3:0]          regSel,
	output      logic [1:0]          pairSel,
	output      logic                pcInc,
	output      logic                flagsUpdate,
	output      logic                flowDone,
	output      logic                busy
);

	ucodePkg::flowIdxT uPc;
	ucodePkg::flowCtlT ctl;
	logic              start;
	logic              issue;
	logic              endNow;
	logic              incNow;
	logic              fuNow;
	logic [3:0]        nextRegSel;
	logic [1:0]        nextPairSel;

	// New flow only once the previous one has issued its last micro-op
	assign start   = !busy && notEmpty;
	assign pop     = start;
	assign issue   = busy || start;
	assign romAddr = start ? headIdx : uPc;

	//////////////////////////////////////////////////
	// Flow-control decode
	//////////////////////////////////////////////////

	assign ctl = romWord.asReg.flowCtl;

	assign incNow = ctl inside {ucodePkg::ctlInc, ucodePkg::ctlIncEof, ucodePkg::ctlIncEofZ,
		ucodePkg::ctlIncEofNz, ucodePkg::ctlIncEofFu};
	assign fuNow = ctl inside {ucodePkg::ctlEofFu, ucodePkg::ctlIncEofFu,
		ucodePkg::ctlUpdateFlags};
	// Z-conditioned ends, otherwise the flow carries on
	assign endNow = (ctl inside {ucodePkg::ctlEof, ucodePkg::ctlIncEof,
		ucodePkg::ctlEofFu, ucodePkg::ctlIncEofFu})
		|| (ctl == ucodePkg::ctlIncEofZ && zeroFlag)
		|| (ctl == ucodePkg::ctlIncEofNz && !zeroFlag);

	// Operand view picked by the pair bit
	always_comb
	begin
		if (romWord.asPair.isPair)
		begin
			// Full pair number so PC shows as 4
			nextRegSel  = {romWord.asPair.spare, romWord.asPair.pairIdx};
			nextPairSel = romWord.asPair.pairIdx;
		end
		else
		begin
			nextRegSel  = romWord.asReg.operand[3:0];
			nextPairSel = 2'd0;
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			uopValid    <= 1'b0;
			pcInc       <= 1'b0;
			flagsUpdate <= 1'b0;
			flowDone    <= 1'b0;
			busy        <= 1'b0;
		end
		else
		begin
			uopValid    <= issue;
			pcInc       <= issue && incNow;
			flagsUpdate <= issue && fuNow;
			flowDone    <= issue && endNow;
			busy        <= issue && !endNow;
		end
	end

	always_ff @(posedge clock)
	begin
		if (issue)
		begin
			uPc          <= romAddr + 7'd1;
			uopOperation <= romWord.asReg.operation;
			isPair       <= romWord.asPair.isPair;
			regSel       <= nextRegSel;
			pairSel      <= nextPairSel;
		end
	end

endmodule

`default_nettype wire

/* verilog/ucodeEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module ucodeEngine
#(
	parameter int queueDepth = 4
)
(
	input  wire logic            clock,
	input  wire logic            rstN,
	input  wire logic            opValid,
	input  wire logic [7:0]      opcode,
	input  wire logic            zeroFlag,
	output      logic            uopValid,
	output      ucodePkg::uopOpT uopOperation,
	output      logic            isPair,
	output      logic [3:0]      regSel,
	output      logic [1:0]      pairSel,
	output      logic            pcInc,
	output      logic            flagsUpdate,
	output      logic            flowDone,
	output      logic            busy,
	output      logic            overflow
);

	logic                flowValid;
	ucodePkg::flowIdxT   flowIdx;
	logic                notEmpty;
	ucodePkg::flowIdxT   headIdx;
	logic                pop;
	ucodePkg::flowIdxT   romAddr;
	ucodePkg::ucodeWordU romWord;

	//////////////////////////////////////////////////
	// Dispatch, queue, ROM and sequencer
	//////////////////////////////////////////////////

	opcodeDispatch dispatch
	(
		.clock     (clock),
		.rstN      (rstN),
		.opValid   (opValid),
		.opcode    (opcode),
		.flowValid (flowValid),
		.flowIdx   (flowIdx)
	);

	flowQueue #(.queueDepth(queueDepth)) queue
	(
		.clock    (clock),
		.rstN     (rstN),
		.push     (flowValid),
		.pushIdx  (flowIdx),
		.pop      (pop),
		.notEmpty (notEmpty),
		.headIdx  (headIdx),
		.overflow (overflow)
	);

	ucodeRom rom
	(
		.addr (romAddr),
		.word (romWord)
	);

	ucodeSequencer sequencer
	(
		.clock        (clock),
		.rstN         (rstN),
		.notEmpty     (notEmpty),
		.headIdx      (headIdx),
		.zeroFlag     (zeroFlag),
		.pop          (pop),
		.romAddr      (romAddr),
		.romWord      (romWord),
		.uopValid     (uopValid),
		.uopOperation (uopOperation),
		.isPair       (isPair),
		.regSel       (regSel),
		.pairSel      (pairSel),
		.pcInc        (pcInc),
		.flagsUpdate  (flagsUpdate),
		.flowDone     (flowDone),
		.busy         (busy)
	);

endmodule

`default_nettype wire

/* dv/uopChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module uopChecker
(
	input  wire logic            clock,
	input  wire logic            uopValid,
	input  wire ucodePkg::uopOpT uopOperation,
	input  wire logic            isPair,
	input  wire logic [3:0]      regSel,
	input  wire logic [1:0]      pairSel,
	input  wire logic            pcInc,
	input  wire logic            flagsUpdate,
	input  wire logic            flowDone,
	input  wire logic            busy,
	input  wire logic            expPush,
	input  wire logic [4:0]      expOp,
	input  wire logic [4:0]      expOperand,
	input  wire logic            expInc,
	input  wire logic            expFu,
	input  wire logic            expLast,
	input  wire logic [31:0]     expTest,
	output      int              errorCount,
	output      int              testsDone,
	output      int              pending
);

	logic [4:0] qOp[$];
	logic [4:0] qOperand[$];
	logic       qInc[$];
	logic       qFu[$];
	logic       qLast[$];
	int         qTest[$];
	logic       testBad = 1'b0;
	int         errors = 0;
	int         done = 0;

	assign errorCount = errors;
	assign testsDone  = done;

	task automatic reportFail(input int t, input string msg);
		$display("Fail %0t: test %0d %s", $time, t, msg);
		errors++;
		testBad = 1'b1;
	endtask

	always @(posedge clock)
	begin : compare
		logic [4:0] op;
		logic [4:0] operand;
		logic       last;
		int         t;
		if (expPush)
		begin
			qOp.push_back(expOp);
			qOperand.push_back(expOperand);
			qInc.push_back(expInc);
			qFu.push_back(expFu);
			qLast.push_back(expLast);
			qTest.push_back(expTest);
		end
		if (uopValid)
		begin
			if (qOp.size() == 0)
			begin
				$display("Extra micro-op at %0t with no expected stream pending", $time);
				errors++;
			end
			else
			begin
				op      = qOp.pop_front();
				operand = qOperand.pop_front();
				last    = qLast.pop_front();
				t       = qTest.pop_front();
				if (uopOperation !== op)
					reportFail(t, $sformatf("operation %0d, expected %0d", uopOperation, op));
				if (isPair !== operand[4])
					reportFail(t, $sformatf("isPair %b, expected %b", isPair, operand[4]));
				else if (operand[4] && pairSel !== operand[1:0])
					reportFail(t, $sformatf("pairSel %0d, expected %0d", pairSel, operand[1:0]));
				else if (!operand[4] && regSel !== operand[3:0])
					reportFail(t, $sformatf("regSel %0d, expected %0d", regSel, operand[3:0]));
				if (pcInc !== qInc.pop_front())
					reportFail(t, "pcInc wrong");
				if (flagsUpdate !== qFu.pop_front())
					reportFail(t, "flagsUpdate wrong");
				// Busy stays up while more micro-ops of the flow follow
				if (busy !== !last)
					reportFail(t, $sformatf("busy %b, expected %b", busy, !last));
				if (last && !flowDone)
				begin
					$display("Test %0d ended its stream without flowDone at %0t", t, $time);
					errors++;
					testBad = 1'b1;
				end
				if (!last && flowDone)
				begin
					$display("Test %0d raised flowDone before its last micro-op at %0t", t, $time);
					errors++;
					testBad = 1'b1;
				end
				// One line per finished test
				if (last || flowDone)
				begin
					$display("Test %0d %s", t, testBad ? "failed" : "passed");
					done++;
					testBad = 1'b0;
				end
			end
		end
		pending = qOp.size();
	end

endmodule

`default_nettype wire

/* dv/tbUcodeEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module tbUcodeEngine;

	localparam int queueDepth  = 4;
	localparam int resetCycles = 8;
	localparam int numRows     = 15;
	localparam int maxUops     = 6;

	logic            clock = 1'b0;
	logic            rstN;
	logic            opValid;
	logic [7:0]      opcode;
	logic            zeroFlag;
	logic            uopValid;
	ucodePkg::uopOpT uopOperation;
	logic            isPair;
	logic [3:0]      regSel;
	logic [1:0]      pairSel;
	logic            pcInc;
	logic            flagsUpdate;
	logic            flowDone;
	logic            busy;
	logic            overflow;

	logic       expPush;
	logic [4:0] expOp;
	logic [4:0] expOperand;
	logic       expInc;
	logic       expFu;
	logic       expLast;
	int         expTest;
	int         chkErrors;
	int         chkTests;
	int         chkPending;

	// Stimulus table, one row per flow
	logic [7:0] opcodeTab[numRows];
	logic       cbTab[numRows];
	logic       zfTab[numRows];
	int         gapTab[numRows];
	int         cntTab[numRows];
	logic       jrTab[numRows];
	logic [4:0] opTab[numRows][maxUops];
	logic [4:0] operandTab[numRows][maxUops];
	logic       incTab[numRows][maxUops];
	logic       fuTab[numRows][maxUops];
	logic       rndZf[numRows];
	int         rndGap[numRows];
	int         burstRows[6] = '{7, 8, 10, 7, 8, 2};

	integer seed;
	int     cycles = 0;
	int     limit = 0;
	int     tbErrors = 0;
	int     testId = 0;

	ucodeEngine #(.queueDepth(queueDepth)) uut
	(
		.clock(clock), .rstN(rstN), .opValid(opValid), .opcode(opcode), .zeroFlag(zeroFlag),
		.uopValid(uopValid), .uopOperation(uopOperation), .isPair(isPair), .regSel(regSel),
		.pairSel(pairSel), .pcInc(pcInc), .flagsUpdate(flagsUpdate), .flowDone(flowDone),
		.busy(busy), .overflow(overflow)
	);

	uopChecker uopCheck
	(
		.clock(clock), .uopValid(uopValid), .uopOperation(uopOperation), .isPair(isPair),
		.regSel(regSel), .pairSel(pairSel), .pcInc(pcInc), .flagsUpdate(flagsUpdate),
		.flowDone(flowDone), .busy(busy), .expPush(expPush), .expOp(expOp),
		.expOperand(expOperand), .expInc(expInc), .expFu(expFu), .expLast(expLast),
		.expTest(expTest), .errorCount(chkErrors), .testsDone(chkTests),
		.pending(chkPending)
	);

	always #4 clock = ~clock;

	always @(posedge clock)
	begin
		cycles++;
		if (limit > 0 && cycles > limit)
		begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic tick();
		@(posedge clock);
		#1;
	endtask

	task automatic setRow(input int e, input logic cb, input logic [7:0] opc,
		input logic zf, input int gap);
		opcodeTab[e] = opc;
		cbTab[e]     = cb;
		zfTab[e]     = zf;
		gapTab[e]    = gap;
		cntTab[e]    = 0;
		jrTab[e]     = !cb && (opc == ucodePkg::opcJrNz);
	endtask

	task automatic addUop(input int e, input ucodePkg::uopOpT op, input logic [4:0] operand,
		input logic inc, input logic fu);
		opTab[e][cntTab[e]]      = op;
		operandTab[e][cntTab[e]] = operand;
		incTab[e][cntTab[e]]     = inc;
		fuTab[e][cntTab[e]]      = fu;
		cntTab[e]++;
	endtask

	// JR NZ,n stops after its third micro-op when Z is set
	function automatic int flowLength(input int e, input logic zf);
		return (jrTab[e] && zf) ? 3 : cntTab[e];
	endfunction

	task automatic sendExpected(input int e, input logic zf, input int t);
		int n;
		n = flowLength(e, zf);
		for (int i = 0; i < n; i++)
		begin
			expPush    = 1'b1;
			expOp      = opTab[e][i];
			expOperand = operandTab[e][i];
			expInc     = incTab[e][i];
			expFu      = fuTab[e][i];
			expLast    = (i == n - 1);
			expTest    = t;
			tick();
		end
		expPush = 1'b0;
	endtask

	task automatic strobeOpcode(input logic [7:0] b);
		opValid = 1'b1;
		opcode  = b;
		tick();
		opValid = 1'b0;
	endtask

	task automatic runRow(input int e, input logic zf, input int gap, input logic checkLatency);
		int n;
		testId++;
		zeroFlag = zf;
		sendExpected(e, zf, testId);
		if (cbTab[e])
		begin
			strobeOpcode(ucodePkg::opcCbPrefix);
			repeat (5) tick();
		end
		strobeOpcode(opcodeTab[e]);
		n = 1;
		while (!uopValid && n < 20)
		begin
			tick();
			n++;
		end
		if (checkLatency && n != 3)
		begin
			$display("Fail %0t: test %0d first micro-op after %0d cycles, expected 3",
				$time, testId, n);
			tbErrors++;
		end
		n = 0;
		while (!flowDone && n < 20)
		begin
			tick();
			n++;
		end
		if (!flowDone)
		begin
			$display("Test %0d never signalled flowDone", testId);
			tbErrors++;
		end
		repeat (gap) tick();
	endtask

	// Back to back strobes, the sixth one overruns the queue
	task automatic runBurst(input int n, input logic expOverflow);
		int kept;
		int dones;
		int idle;
		kept = (n > 5) ? 5 : n;
		dones = 0;
		idle = 0;
		zeroFlag = 1'b0;
		for (int i = 0; i < kept; i++)
		begin
			testId++;
			sendExpected(burstRows[i], 1'b0, testId);
		end
		for (int i = 0; i < n; i++)
			strobeOpcode(opcodeTab[burstRows[i]]);
		opValid = 1'b0;
		while (!uopValid)
			tick();
		while (dones < kept)
		begin
			if (!uopValid)
				idle++;
			if (flowDone)
				dones++;
			tick();
		end
		if (idle != 0)
		begin
			$display("Fail %0t: burst of %0d had %0d idle cycles, expected 0", $time, n, idle);
			tbErrors++;
		end
		if (overflow !== expOverflow)
		begin
			$display("Fail %0t: overflow %b, expected %b", $time, overflow, expOverflow);
			tbErrors++;
		end
		repeat (4) tick();
	endtask

	task automatic buildTable();
		setRow(0, 1'b0, ucodePkg::opcNop, 1'b0, 2);
		addUop(0, ucodePkg::opNop, ucodePkg::regNull, 1'b1, 1'b0);
		setRow(1, 1'b0, ucodePkg::opcLdBn, 1'b0, 2);
		addUop(1, ucodePkg::opSma, ucodePkg::pairPc, 1'b1, 1'b0);
		addUop(1, ucodePkg::opNop, ucodePkg::regNull, 1'b1, 1'b0);
		addUop(1, ucodePkg::opSrm, ucodePkg::regB, 1'b0, 1'b0);
		setRow(2, 1'b0, ucodePkg::opcIncB, 1'b0, 1);
		addUop(2, ucodePkg::opInc16, ucodePkg::regB, 1'b1, 1'b1);
		setRow(3, 1'b0, ucodePkg::opcDecA, 1'b0, 1);
		addUop(3, ucodePkg::opDec16, ucodePkg::regA, 1'b1, 1'b1);
		setRow(4, 1'b0, ucodePkg::opcAddAB, 1'b0, 0);
		addUop(4, ucodePkg::opSx16r, ucodePkg::regA, 1'b0, 1'b0);
		addUop(4, ucodePkg::opAddx16, ucodePkg::regB, 1'b0, 1'b1);
		addUop(4, ucodePkg::opSrx16, ucodePkg::regA, 1'b1, 1'b0);
		setRow(5, 1'b0, ucodePkg::opcSubC, 1'b0, 0);
		addUop(5, ucodePkg::opSx16r, ucodePkg::regA, 1'b0, 1'b0);
		addUop(5, ucodePkg::opSubx16, ucodePkg::regC, 1'b0, 1'b1);
		addUop(5, ucodePkg::opSrx16, ucodePkg::regA, 1'b1, 1'b0);
		setRow(6, 1'b0, ucodePkg::opcIncHl, 1'b0, 3);
		addUop(6, ucodePkg::opInc16, ucodePkg::pairHl, 1'b1, 1'b0);
		setRow(7, 1'b0, ucodePkg::opcPushBc, 1'b0, 1);
		addUop(7, ucodePkg::opDec16, ucodePkg::pairSp, 1'b0, 1'b0);
		addUop(7, ucodePkg::opSma, ucodePkg::pairSp, 1'b0, 1'b0);
		addUop(7, ucodePkg::opSmw, ucodePkg::regB, 1'b0, 1'b0);
		addUop(7, ucodePkg::opDec16, ucodePkg::pairSp, 1'b0, 1'b0);
		addUop(7, ucodePkg::opSmw, ucodePkg::regC, 1'b0, 1'b0);
		addUop(7, ucodePkg::opSma, ucodePkg::pairPc, 1'b1, 1'b0);
		setRow(8, 1'b0, ucodePkg::opcPopBc, 1'b0, 1);
		addUop(8, ucodePkg::opSma, ucodePkg::pairSp, 1'b0, 1'b0);
		addUop(8, ucodePkg::opInc16, ucodePkg::pairSp, 1'b0, 1'b0);
		addUop(8, ucodePkg::opSrm, ucodePkg::regC, 1'b0, 1'b0);
		addUop(8, ucodePkg::opSrm, ucodePkg::regB, 1'b0, 1'b0);
		addUop(8, ucodePkg::opInc16, ucodePkg::pairSp, 1'b1, 1'b0);
		addUop(8, ucodePkg::opSma, ucodePkg::pairPc, 1'b0, 1'b0);
		// JR NZ,n twice, taken and not taken
		for (int e = 9; e <= 10; e++)
		begin
			setRow(e, 1'b0, ucodePkg::opcJrNz, (e == 9), 2);
			addUop(e, ucodePkg::opSma, ucodePkg::pairPc, 1'b1, 1'b0);
			addUop(e, ucodePkg::opNop, ucodePkg::regNull, 1'b0, 1'b0);
			addUop(e, ucodePkg::opSrm, ucodePkg::regX8, 1'b1, 1'b0);
			addUop(e, ucodePkg::opSx16r, ucodePkg::pairPc, 1'b0, 1'b0);
			addUop(e, ucodePkg::opAddx8, ucodePkg::regX8, 1'b0, 1'b0);
			addUop(e, ucodePkg::opSpc, ucodePkg::pairPc, 1'b0, 1'b0);
		end
		setRow(11, 1'b0, 8'h3E, 1'b0, 1);
		addUop(11, ucodePkg::opZ801bop, ucodePkg::regA, 1'b0, 1'b1);
		addUop(11, ucodePkg::opNop, ucodePkg::regNull, 1'b1, 1'b0);
		setRow(12, 1'b1, ucodePkg::cbBit7H, 1'b0, 1);
		addUop(12, ucodePkg::opBit, ucodePkg::regH, 1'b0, 1'b1);
		setRow(13, 1'b1, ucodePkg::cbRlC, 1'b0, 1);
		addUop(13, ucodePkg::opShl, ucodePkg::regC, 1'b0, 1'b1);
		setRow(14, 1'b1, 8'h55, 1'b0, 2);
		addUop(14, ucodePkg::opNop, ucodePkg::regNull, 1'b0, 1'b0);
	endtask

	initial
	begin
		int rnd;
		int total;
		rstN     = 1'b0;
		opValid  = 1'b0;
		opcode   = 8'h00;
		zeroFlag = 1'b0;
		expPush  = 1'b0;
		expOp    = '0;
		expOperand = '0;
		expInc   = 1'b0;
		expFu    = 1'b0;
		expLast  = 1'b0;
		expTest  = 0;
		seed     = 32'h5c63a72d;
		buildTable();
		total = 0;
		for (int e = 0; e < numRows; e++)
		begin
			rnd       = $random(seed);
			rndZf[e]  = rnd[0];
			rndGap[e] = (rnd >>> 1) & 3;
			total += 2 * cntTab[e] + gapTab[e] + 4 + (cbTab[e] ? 6 : 0);
			total += 2 * cntTab[e] + rndGap[e] + 4 + (cbTab[e] ? 6 : 0);
		end
		// Two bursts of six flows of up to six micro-ops
		total += 2 * (2 * 36 + 6 + 8);
		limit = resetCycles + 2 * total;

		repeat (resetCycles) @(posedge clock);
		#1;
		rstN = 1'b1;
		tick();

		for (int e = 0; e < numRows; e++)
			runRow(e, zfTab[e], gapTab[e], 1'b1);
		for (int e = 0; e < numRows; e++)
			runRow(e, rndZf[e], rndGap[e], 1'b0);
		runBurst(5, 1'b0);
		runBurst(6, 1'b1);

		if (chkPending != 0)
		begin
			$display("Expected micro-ops never arrived, %0d left over", chkPending);
			tbErrors++;
		end
		$display("Tests %0d, checker errors %0d, testbench errors %0d",
			chkTests, chkErrors, tbErrors);
		if (chkErrors == 0 && tbErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/ucodePkg.sv
verilog/opcodeDispatch.sv
verilog/flowQueue.sv
verilog/ucodeRom.sv
verilog/ucodeSequencer.sv
verilog/ucodeEngine.sv
dv/uopChecker.sv
dv/tbUcodeEngine.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tbUcodeEngine -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/VtbUcodeEngine)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
	exit 0
fi
exit 1
